/* include/fsqrt_config.svh */
/*
  Field widths, bias and encodings for the single-precision square root.
  FSQRT_ROOT_W is also the iteration count of the digit recurrence.
  Rounding codes 5 to 7 are treated as RNE by the rounder.
*/
`ifndef FSQRT_CONFIG_SVH
`define FSQRT_CONFIG_SVH

// ==============================
// Float format
// ==============================
`define FSQRT_EXP_W   8
`define FSQRT_MANT_W  23
`define FSQRT_BIAS    127

// 24 result bits plus guard, round and one extra
`define FSQRT_ROOT_W  27

// ==============================
// Rounding modes
// ==============================
`define FSQRT_FRM_RNE 3'd0
`define FSQRT_FRM_RTZ 3'd1
`define FSQRT_FRM_RDN 3'd2
`define FSQRT_FRM_RUP 3'd3
`define FSQRT_FRM_RMM 3'd4

// Special results
`define FSQRT_QNAN    32'h7FC0_0000
`define FSQRT_POS_INF 32'h7F80_0000

// Edges from acceptance to o_valid, acceptance edge included
`define FSQRT_LATENCY 30

`endif

/* src/fsqrt_pkg.sv */
/*
  Shared types for the square-root unit.
  Widths follow the macros in the config header.
*/
`include "fsqrt_config.svh"

package fsqrt_pkg;

  // Raw IEEE single word
  typedef logic [`FSQRT_EXP_W+`FSQRT_MANT_W:0] float_t;

  // Working exponent, signed so subnormal inputs fit
  typedef logic signed [9:0] exp_t;

  // Rounding mode code
  typedef logic [2:0] frm_t;

  // Root accumulator
  typedef logic [`FSQRT_ROOT_W-1:0] root_t;

  // Partial remainder, two bits wider than the trial divisor
  typedef logic [2*`FSQRT_ROOT_W+1:0] rem_t;

  // Radicand, two bits consumed per iteration
  typedef logic [2*`FSQRT_ROOT_W-1:0] rad_t;

  // Engine sequencing
  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_SETUP,
    ENG_ITERATE,
    ENG_FINISH
  } engine_state_t;

endpackage : fsqrt_pkg

/* src/fsqrt_root_if.sv */
/*
  Raw root from the engine to the rounder.
  Payload is only meaningful while done is high.
*/
`timescale 1ns/1ps

interface fsqrt_root_if;
  import fsqrt_pkg::*;

  // Root bits, MSB always set for a nonzero radicand
  root_t root;
  // Nonzero remainder after the last iteration
  logic  sticky;
  // Biased result exponent
  exp_t  res_exp;
  // One-cycle pulse, payload valid
  logic  done;

  // Engine side
  modport source (
    output root,
    output sticky,
    output res_exp,
    output done
  );

  // Rounder side
  modport sink (
    input root,
    input sticky,
    input res_exp,
    input done
  );

endinterface : fsqrt_root_if

/* src/fsqrt_classify.sv */
/*
  Special-case decode of the operand, in parallel with the root engine.
  Verdict lands one edge after acceptance and holds until the next one.
  Negative zero is not an invalid case and returns -0.
*/
`timescale 1ns/1ps
`include "fsqrt_config.svh"

module fsqrt_classify (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_accept,
  input  fsqrt_pkg::float_t i_operand,
  output logic              o_is_special,
  output fsqrt_pkg::float_t o_special_result,
  output logic              o_special_invalid
);
  import fsqrt_pkg::*;

  localparam int EXP_W  = `FSQRT_EXP_W;
  localparam int MANT_W = `FSQRT_MANT_W;

  float_t              operand_q;
  logic                accept_q;

  // Field split
  logic                sign;
  logic [EXP_W-1:0]    exp_f;
  logic [MANT_W-1:0]   mant_f;
  logic                is_nan;
  logic                is_snan;
  logic                is_inf;
  logic                is_zero;

  assign sign   = operand_q[EXP_W+MANT_W];
  assign exp_f  = operand_q[EXP_W+MANT_W-1:MANT_W];
  assign mant_f = operand_q[MANT_W-1:0];

  assign is_nan  = (&exp_f) && (|mant_f);
  // Quiet bit clear marks a signaling NaN
  assign is_snan = is_nan && !mant_f[MANT_W-1];
  assign is_inf  = (&exp_f) && !(|mant_f);
  assign is_zero = !(|exp_f) && !(|mant_f);

  // Operand capture
  always_ff @(posedge i_clk) begin
    if (i_accept) begin
      operand_q <= i_operand;
    end
  end

  // ==============================
  // Registered verdict
  // ==============================
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      accept_q          <= 1'b0;
      o_is_special      <= 1'b0;
      o_special_result  <= '0;
      o_special_invalid <= 1'b0;
    end else begin
      accept_q <= i_accept;
      if (accept_q) begin
        // Priority: NaN, negative, +inf, zero
        o_is_special      <= 1'b1;
        o_special_invalid <= 1'b0;
        if (is_nan) begin
          o_special_result  <= `FSQRT_QNAN;
          o_special_invalid <= is_snan;
        end else if (sign && !is_zero) begin
          o_special_result  <= `FSQRT_QNAN;
          o_special_invalid <= 1'b1;
        end else if (is_inf) begin
          o_special_result <= `FSQRT_POS_INF;
        end else if (is_zero) begin
          // Sign of zero passes through
          o_special_result <= {sign, {(EXP_W+MANT_W){1'b0}}};
        end else begin
          o_is_special     <= 1'b0;
          o_special_result <= '0;
        end
      end
    end
  end

endmodule : fsqrt_classify

/* src/fsqrt_root_engine.sv */
/*
  Digit-by-digit square root, one root bit per ITERATE cycle.
  Runs for every operand, special ones included, so latency is fixed.
  Only one operation in flight; i_valid is ignored while busy.
*/
`timescale 1ns/1ps
`include "fsqrt_config.svh"

module fsqrt_root_engine (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_valid,
  input  fsqrt_pkg::float_t i_operand,
  output logic              o_accept,
  output logic              o_busy,
  fsqrt_root_if.source      o_root_bus
);
  import fsqrt_pkg::*;

  localparam int EXP_W  = `FSQRT_EXP_W;
  localparam int MANT_W = `FSQRT_MANT_W;
  localparam int ROOT_W = `FSQRT_ROOT_W;
  localparam int CNT_W  = $clog2(ROOT_W);
  // Zero fill below the 25-bit radicand mantissa
  localparam int PAD_W  = 2 * ROOT_W - (MANT_W + 2);

  engine_state_t      state;
  logic [CNT_W-1:0]   iter_cnt;
  float_t             operand_q;

  // Recurrence registers
  root_t              root_q;
  rem_t               rem_q;
  rad_t               rad_q;
  exp_t               res_exp_q;

  // Setup decode
  logic [EXP_W-1:0]   exp_f;
  logic [MANT_W-1:0]  mant_f;
  logic [4:0]         lzc;
  logic [4:0]         sub_shift;
  logic               lzc_found;
  exp_t               exp_adj;
  exp_t               exp_unb;
  exp_t               exp_sum;
  logic               exp_odd;
  logic [MANT_W:0]    mant_norm;
  logic [MANT_W+1:0]  mant_int;

  // Recurrence step
  rem_t               rem_cand;
  rem_t               trial;
  logic               rem_ge;

  assign o_accept = (state == ENG_IDLE) && i_valid;
  assign o_busy   = (state != ENG_IDLE);

  assign exp_f  = operand_q[EXP_W+MANT_W-1:MANT_W];
  assign mant_f = operand_q[MANT_W-1:0];

  // ==============================
  // Setup decode
  // ==============================
  always_comb begin
    lzc       = '0;
    lzc_found = 1'b0;
    // Leading zero count of the fraction
    for (int i = MANT_W - 1; i >= 0; i--) begin
      if (!lzc_found) begin
        if (mant_f[i]) begin
          lzc_found = 1'b1;
        end else begin
          lzc = lzc + 5'd1;
        end
      end
    end
    sub_shift = lzc + 5'd1;

    if (exp_f == '0) begin
      // Subnormal, shift first one up to the hidden bit
      mant_norm = {1'b0, mant_f} << sub_shift;
      exp_adj   = 10'sd1 - $signed({5'b0, sub_shift});
    end else begin
      mant_norm = {1'b1, mant_f};
      exp_adj   = $signed({2'b0, exp_f});
    end

    exp_unb = exp_adj - 10'(`FSQRT_BIAS);
    exp_odd = exp_unb[0];

    // Odd exponent: double mantissa, range becomes [1,4)
    if (exp_odd) begin
      mant_int = {mant_norm, 1'b0};
      exp_sum  = exp_adj + 10'(`FSQRT_BIAS - 1);
    end else begin
      mant_int = {1'b0, mant_norm};
      exp_sum  = exp_adj + 10'(`FSQRT_BIAS);
    end
  end

  // Bring down two bits, trial divisor 4*root+1
  assign rem_cand = {rem_q[2*ROOT_W-1:0], rad_q[2*ROOT_W-1 -: 2]};
  assign trial    = {{ROOT_W{1'b0}}, root_q, 2'b01};
  assign rem_ge   = (rem_cand >= trial);

  // ==============================
  // Sequencing
  // ==============================
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= ENG_IDLE;
      iter_cnt <= '0;
    end else begin
      case (state)
        ENG_IDLE: begin
          if (i_valid) begin
            state <= ENG_SETUP;
          end
        end
        ENG_SETUP: begin
          iter_cnt <= '0;
          state    <= ENG_ITERATE;
        end
        ENG_ITERATE: begin
          iter_cnt <= iter_cnt + 1'b1;
          if (iter_cnt == CNT_W'(ROOT_W - 1)) begin
            state <= ENG_FINISH;
          end
        end
        ENG_FINISH: begin
          state <= ENG_IDLE;
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge i_clk) begin
    if (o_accept) begin
      operand_q <= i_operand;
    end
    if (state == ENG_SETUP) begin
      root_q    <= '0;
      rem_q     <= '0;
      rad_q     <= {mant_int, {PAD_W{1'b0}}};
      // Halve the exponent, bias restored by the odd/even sum
      res_exp_q <= exp_sum >>> 1;
    end else if (state == ENG_ITERATE) begin
      rad_q <= {rad_q[2*ROOT_W-3:0], 2'b00};
      if (rem_ge) begin
        rem_q  <= rem_cand - trial;
        root_q <= {root_q[ROOT_W-2:0], 1'b1};
      end else begin
        rem_q  <= rem_cand;
        root_q <= {root_q[ROOT_W-2:0], 1'b0};
      end
    end
  end

  assign o_root_bus.root    = root_q;
  assign o_root_bus.sticky  = |rem_q;
  assign o_root_bus.res_exp = res_exp_q;
  assign o_root_bus.done    = (state == ENG_FINISH);

endmodule : fsqrt_root_engine

/* src/fsqrt_round.sv */
/*
  Rounds the raw root and picks the special or computed result.
  The root is never negative and never overflows or goes subnormal.
  Outputs hold until the next done pulse.
*/
`timescale 1ns/1ps
`include "fsqrt_config.svh"

module fsqrt_round (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_accept,
  input  fsqrt_pkg::frm_t   i_rounding_mode,
  fsqrt_root_if.sink        i_root_bus,
  input  logic              i_is_special,
  input  fsqrt_pkg::float_t i_special_result,
  input  logic              i_special_invalid,
  output fsqrt_pkg::float_t o_result,
  output logic              o_flag_invalid,
  output logic              o_flag_inexact,
  output logic              o_valid
);
  import fsqrt_pkg::*;

  localparam int EXP_W  = `FSQRT_EXP_W;
  localparam int MANT_W = `FSQRT_MANT_W;
  localparam int ROOT_W = `FSQRT_ROOT_W;

  frm_t               frm_q;

  // Root split
  logic [MANT_W:0]    mant_keep;
  logic               guard_bit;
  logic               round_bit;
  logic               sticky_bit;
  logic               round_up;
  logic               inexact;

  // Rounded result
  logic [MANT_W+1:0]  mant_rnd;
  logic               carry;
  logic [MANT_W-1:0]  frac_out;
  exp_t               exp_out;
  float_t             result_rnd;

  always_ff @(posedge i_clk) begin
    if (i_accept) begin
      frm_q <= i_rounding_mode;
    end
  end

  // ==============================
  // Rounding
  // ==============================
  assign mant_keep  = i_root_bus.root[ROOT_W-1 -: MANT_W+1];
  assign guard_bit  = i_root_bus.root[2];
  assign round_bit  = i_root_bus.root[1];
  // Extra root bit and remainder both fold into sticky
  assign sticky_bit = i_root_bus.root[0] | i_root_bus.sticky;
  assign inexact    = guard_bit | round_bit | sticky_bit;

  always_comb begin
    case (frm_q)
      `FSQRT_FRM_RNE: round_up = guard_bit & (round_bit | sticky_bit | mant_keep[0]);
      `FSQRT_FRM_RTZ: round_up = 1'b0;
      // Positive result, round down is truncation
      `FSQRT_FRM_RDN: round_up = 1'b0;
      `FSQRT_FRM_RUP: round_up = inexact;
      `FSQRT_FRM_RMM: round_up = guard_bit;
      default:        round_up = guard_bit & (round_bit | sticky_bit | mant_keep[0]);
    endcase
  end

  assign mant_rnd = {1'b0, mant_keep} + {{(MANT_W+1){1'b0}}, round_up};
  assign carry    = mant_rnd[MANT_W+1];

  // Carry out means all ones rolled over to 1.0, bump exponent
  always_comb begin
    if (carry) begin
      frac_out = mant_rnd[MANT_W:1];
      exp_out  = i_root_bus.res_exp + 10'sd1;
    end else begin
      frac_out = mant_rnd[MANT_W-1:0];
      exp_out  = i_root_bus.res_exp;
    end
  end

  assign result_rnd = {1'b0, exp_out[EXP_W-1:0], frac_out};

  // Output registers
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_result       <= '0;
      o_flag_invalid <= 1'b0;
      o_flag_inexact <= 1'b0;
      o_valid        <= 1'b0;
    end else begin
      o_valid <= i_root_bus.done;
      if (i_root_bus.done) begin
        if (i_is_special) begin
          o_result       <= i_special_result;
          o_flag_invalid <= i_special_invalid;
          o_flag_inexact <= 1'b0;
        end else begin
          o_result       <= result_rnd;
          o_flag_invalid <= 1'b0;
          o_flag_inexact <= inexact;
        end
      end
    end
  end

endmodule : fsqrt_round

/* src/fsqrt_top.sv */
/*
  Single-precision square root with fixed latency.
  Accepts when i_valid is high and o_busy is low; o_valid pulses once.
*/
`timescale 1ns/1ps

module fsqrt_top (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_valid,
  input  fsqrt_pkg::float_t i_operand,
  input  fsqrt_pkg::frm_t   i_rounding_mode,
  output fsqrt_pkg::float_t o_result,
  output logic              o_flag_invalid,
  output logic              o_flag_inexact,
  output logic              o_valid,
  output logic              o_busy
);
  import fsqrt_pkg::*;

  // Acceptance pulse from the engine
  logic   accept;

  // Classifier verdict
  logic   is_special;
  float_t special_result;
  logic   special_invalid;

  // Engine to rounder
  fsqrt_root_if root_bus ();

  fsqrt_classify u_classify (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_accept          (accept),
    .i_operand         (i_operand),
    .o_is_special      (is_special),
    .o_special_result  (special_result),
    .o_special_invalid (special_invalid)
  );

  fsqrt_root_engine u_engine (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_valid    (i_valid),
    .i_operand  (i_operand),
    .o_accept   (accept),
    .o_busy     (o_busy),
    .o_root_bus (root_bus.source)
  );

  fsqrt_round u_round (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_accept          (accept),
    .i_rounding_mode   (i_rounding_mode),
    .i_root_bus        (root_bus.sink),
    .i_is_special      (is_special),
    .i_special_result  (special_result),
    .i_special_invalid (special_invalid),
    .o_result          (o_result),
    .o_flag_invalid    (o_flag_invalid),
    .o_flag_inexact    (o_flag_inexact),
    .o_valid           (o_valid)
  );

endmodule : fsqrt_top

/* dv/fsqrt_assert.sv */
/*
  Handshake and latency properties, bound into fsqrt_top.
  Assumes a single request in flight and a registered o_valid.
  Failures are counted in fail_count for the testbench summary.
*/
`timescale 1ns/1ps
`include "fsqrt_config.svh"

module fsqrt_assert (
  input logic i_clk,
  input logic i_rst,
  input logic i_valid,
  input logic i_busy,
  input logic i_result_valid
);

  int unsigned fail_count = 0;
  logic        accept;
  logic        seen_accept;

  // Same acceptance rule as the engine, seen from the ports
  assign accept = i_valid && !i_busy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      seen_accept <= 1'b0;
    end else if (accept) begin
      seen_accept <= 1'b1;
    end
  end

  // ==============================
  // Properties
  // ==============================
  // Result strobe is a single-cycle pulse
  valid_single_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
    i_result_valid |=> !i_result_valid)
    else begin
      fail_count++;
      $error("o_valid stayed high for two cycles");
    end

  // Acceptance must produce o_valid exactly LATENCY edges later
  latency_forward: assert property (@(posedge i_clk) disable iff (i_rst)
    $past(accept, `FSQRT_LATENCY) |-> i_result_valid)
    else begin
      fail_count++;
      $error("o_valid missing at the fixed latency after acceptance");
    end

  // And o_valid must never rise at any other distance
  latency_backward: assert property (@(posedge i_clk) disable iff (i_rst)
    $rose(i_result_valid) |-> $past(accept, `FSQRT_LATENCY))
    else begin
      fail_count++;
      $error("o_valid rose without an acceptance at the fixed latency");
    end

  // Idle until something is accepted
  idle_after_reset: assert property (@(posedge i_clk) disable iff (i_rst)
    !seen_accept |-> !i_busy)
    else begin
      fail_count++;
      $error("o_busy high after reset before any acceptance");
    end

endmodule : fsqrt_assert

bind fsqrt_top fsqrt_assert u_assert (
  .i_clk          (i_clk),
  .i_rst          (i_rst),
  .i_valid        (i_valid),
  .i_busy         (o_busy),
  .i_result_valid (o_valid)
);

/* dv/fsqrt_tb.sv */
/*
  Testbench for the square-root unit.
  Vectors from dv/fsqrt_testdata.hex, four words each: operand, mode,
  expected result, flags {invalid, inexact}. Random RTZ operands are
  checked against a double-precision bracket around the true root.
*/
`timescale 1ns/1ps
`include "fsqrt_config.svh"

module fsqrt_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int LATENCY      = `FSQRT_LATENCY;
  localparam int MAX_VEC      = 64;
  localparam int NUM_RANDOM   = 200;
  // Every operation with its idle gap, plus handshake run, reset and margin
  localparam int WATCHDOG_CYCLES = (MAX_VEC + NUM_RANDOM + 4) * (LATENCY + 5) + 200;

  logic        i_clk;
  logic        i_rst;
  logic        i_valid;
  logic [31:0] i_operand;
  logic [2:0]  i_rounding_mode;
  logic [31:0] o_result;
  logic        o_flag_invalid;
  logic        o_flag_inexact;
  logic        o_valid;
  logic        o_busy;

  // Four words per vector
  logic [31:0] vec_mem [0:4*MAX_VEC-1];
  int          num_vec;
  int          checks;
  int          errors;
  int unsigned lcg_state;

  fsqrt_top UUT (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .i_operand       (i_operand),
    .i_rounding_mode (i_rounding_mode),
    .o_result        (o_result),
    .o_flag_invalid  (o_flag_invalid),
    .o_flag_inexact  (o_flag_inexact),
    .o_valid         (o_valid),
    .o_busy          (o_busy)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ==============================
  // Helpers
  // ==============================
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Positive normal single widened to double, exact
  function automatic real single_to_real(input logic [31:0] f);
    logic [10:0] dexp;
    dexp = {3'b000, f[30:23]} + 11'd896;
    return $bitstoreal({f[31], dexp, f[22:0], 29'b0});
  endfunction

  // One ulp of a positive normal single
  function automatic real single_ulp(input logic [31:0] f);
    logic [10:0] dexp;
    dexp = {3'b000, f[30:23]} + 11'd896 - 11'd23;
    return $bitstoreal({1'b0, dexp, 52'b0});
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Error at %0d ns: %s: got %08h, expected %08h", $time, what, got, expected);
    end
  endtask

  // One request, waits for o_valid, counts edges from acceptance
  task automatic run_op(input logic [31:0] operand, input logic [2:0] mode,
                        output logic [31:0] result, output logic [1:0] flags,
                        output int latency);
    int   edges;
    logic got_valid;
    edges     = 0;
    got_valid = 1'b0;
    @(negedge i_clk);
    while (o_busy) @(negedge i_clk);
    i_operand       = operand;
    i_rounding_mode = mode;
    i_valid         = 1'b1;
    while (!got_valid && edges < LATENCY + 10) begin
      @(posedge i_clk);
      edges++;
      @(negedge i_clk);
      i_valid   = 1'b0;
      got_valid = o_valid;
    end
    if (!got_valid) begin
      errors++;
      $display("No result: o_valid did not rise within %0d cycles for operand %08h",
               edges, operand);
    end
    result  = o_result;
    flags   = {o_flag_invalid, o_flag_inexact};
    latency = edges;
  endtask

  // i_valid held through busy with a changing operand
  task automatic check_handshake();
    int          pulses;
    int          first_edge;
    logic [31:0] first_result;
    pulses       = 0;
    first_edge   = 0;
    first_result = '0;
    @(negedge i_clk);
    while (o_busy) @(negedge i_clk);
    i_operand       = 32'h4080_0000;
    i_rounding_mode = `FSQRT_FRM_RNE;
    i_valid         = 1'b1;
    for (int edge_n = 1; edge_n <= LATENCY + 10; edge_n++) begin
      @(posedge i_clk);
      @(negedge i_clk);
      if (edge_n == 1) begin
        check_value("o_busy after acceptance", {31'b0, o_busy}, 32'd1);
        // Must not reach the datapath
        i_operand = 32'hBF80_0000;
      end
      if (edge_n == 12) begin
        i_valid = 1'b0;
      end
      if (o_valid) begin
        pulses++;
        if (pulses == 1) begin
          first_edge   = edge_n;
          first_result = o_result;
        end
      end
    end
    check_value("o_valid pulses per request", pulses, 32'd1);
    check_value("handshake latency", first_edge, LATENCY);
    check_value("handshake result", first_result, 32'h4000_0000);
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    int          err_before;
    int          latency;
    int          assert_fails;
    logic [31:0] result;
    logic [31:0] operand;
    logic [31:0] r_exp;
    logic [31:0] r_mant;
    logic [7:0]  exp_field;
    logic [1:0]  flags;
    real         op_r;
    real         res_r;
    real         next_r;

    i_rst           = 1'b1;
    i_valid         = 1'b0;
    i_operand       = '0;
    i_rounding_mode = '0;
    checks          = 0;
    errors          = 0;
    lcg_state       = 11;

    // Mode word of an unused slot is always above 7
    for (int a = 0; a < 4 * MAX_VEC; a++) begin
      vec_mem[a] = 32'hA500_0000 ^ a;
    end
    $readmemh("dv/fsqrt_testdata.hex", vec_mem);
    num_vec = 0;
    while (num_vec < MAX_VEC && vec_mem[4*num_vec+1] <= 32'd7) num_vec++;
    if (num_vec == 0) begin
      errors++;
      $display("No vectors could be read from dv/fsqrt_testdata.hex");
    end

    repeat (RESET_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    check_value("o_valid after reset", {31'b0, o_valid}, 32'd0);
    check_value("o_busy after reset", {31'b0, o_busy}, 32'd0);
    check_value("o_result after reset", o_result, 32'd0);

    // File vectors
    for (int v = 0; v < num_vec; v++) begin
      err_before = errors;
      run_op(vec_mem[4*v], vec_mem[4*v+1][2:0], result, flags, latency);
      check_value($sformatf("vector %0d result", v), result, vec_mem[4*v+2]);
      check_value($sformatf("vector %0d flags", v), {30'b0, flags}, vec_mem[4*v+3]);
      check_value($sformatf("vector %0d latency", v), latency, LATENCY);
      $display("Test vector %0d: operand %08h mode %0d result %08h %s", v, vec_mem[4*v],
               vec_mem[4*v+1], result, (errors == err_before) ? "ok" : "mismatch");
    end

    // Random RTZ, result must bracket the true root
    err_before = errors;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r_exp     = next_random();
      r_mant    = next_random();
      exp_field = r_exp[31:24] % 8'd254 + 8'd1;
      operand   = {1'b0, exp_field, r_mant[31:9]};
      run_op(operand, `FSQRT_FRM_RTZ, result, flags, latency);
      op_r   = single_to_real(operand);
      res_r  = single_to_real(result);
      next_r = res_r + single_ulp(result);
      check_value($sformatf("random %08h positive normal", operand),
                  {31'b0, !result[31] && (result[30:23] != 8'd0)}, 32'd1);
      check_value($sformatf("random %08h root squared within operand", operand),
                  {31'b0, res_r * res_r <= op_r}, 32'd1);
      check_value($sformatf("random %08h operand below next root squared", operand),
                  {31'b0, op_r < next_r * next_r}, 32'd1);
      check_value($sformatf("random %08h inexact", operand),
                  {31'b0, flags[0]}, {31'b0, res_r * res_r != op_r});
      check_value($sformatf("random %08h invalid", operand), {31'b0, flags[1]}, 32'd0);
      check_value($sformatf("random %08h latency", operand), latency, LATENCY);
    end
    $display("Test random_rtz: %0d operands %s", NUM_RANDOM,
             (errors == err_before) ? "ok" : "mismatch");

    err_before = errors;
    check_handshake();
    $display("Test handshake: %s", (errors == err_before) ? "ok" : "mismatch");

    assert_fails = int'(UUT.u_assert.fail_count);
    errors       = errors + assert_fails;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, assert_fails);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : fsqrt_tb

/* dv/fsqrt_testdata.hex */
// operand mode expected flags, hex; mode 0 RNE 1 RTZ 2 RDN 3 RUP 4 RMM, others RNE
// flags bit 1 invalid, bit 0 inexact
7FC00000 0 7FC00000 0 // qNaN
7F800001 0 7FC00000 2 // sNaN
FFC00000 0 7FC00000 0 // negative qNaN
BF800000 0 7FC00000 2 // -1.0
FF800000 0 7FC00000 2 // -inf
7F800000 0 7F800000 0 // +inf
80000000 0 80000000 0 // -0
00000000 0 00000000 0 // +0
40800000 0 40000000 0 // 4.0
3E800000 0 3F000000 0 // 0.25
3F800000 0 3F800000 0 // 1.0
41100000 0 40400000 0 // 9.0
40100000 3 3FC00000 0 // 2.25 RUP, exact
40000000 0 3FB504F3 1 // sqrt(2) RNE
40000000 1 3FB504F3 1 // sqrt(2) RTZ
40000000 2 3FB504F3 1 // sqrt(2) RDN
40000000 3 3FB504F4 1 // sqrt(2) RUP
40000000 4 3FB504F3 1 // sqrt(2) RMM, guard bit clear
40000000 7 3FB504F3 1 // sqrt(2) unknown code as RNE
40A00000 0 400F1BBD 1 // sqrt(5) RNE rounds up
40A00000 1 400F1BBC 1 // sqrt(5) RTZ
40A00000 4 400F1BBD 1 // sqrt(5) RMM
00000001 0 1A3504F3 1 // 2^-149
00400000 0 1FB504F3 1 // 2^-127
00200000 1 1F800000 0 // 2^-128, exact

/* tb.f */
+incdir+include
src/fsqrt_pkg.sv
src/fsqrt_root_if.sv
src/fsqrt_classify.sv
src/fsqrt_root_engine.sv
src/fsqrt_round.sv
src/fsqrt_top.sv
dv/fsqrt_assert.sv
dv/fsqrt_tb.sv

/* Makefile */
# Verilator build and run of the square-root testbench

VERILATOR ?= verilator
TOP       ?= fsqrt_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
SIMARGS   ?= +verilator+error+limit+1000
PASS_MSG  := *** TEST PASSED ***

SOURCES := $(wildcard include/*.svh src/*.sv dv/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS SIMARGS"

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIMARGS) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
